// ==== design/pu_spi_params.svh ====
`ifndef PU_SPI_PARAMS_SVH
`define PU_SPI_PARAMS_SVH

// System side word and attribute widths
`define PU_DATA_WIDTH 32
`define PU_ATTR_WIDTH 4

// Serial byte width
`define SPI_DATA_WIDTH 8

// Words held by each queue
`define PU_BUF_SIZE 6

// Flip-flops in each pin synchronizer
`define SPI_SYNC_STAGES 2

`endif

// ==== design/pu_bus_pkg.sv ====
`include "pu_spi_params.svh"

package pu_bus_pkg;

  // One word on the system bus
  typedef logic [`PU_DATA_WIDTH-1:0] pu_word_t;

  // Attribute field that travels with a word
  typedef logic [`PU_ATTR_WIDTH-1:0] pu_attr_t;

  // Set when a read returned a queued word
  localparam int PU_ATTR_VALID = 0;

  // Registered read response
  typedef struct packed {
    pu_word_t data;
    pu_attr_t attr;
  } pu_read_t;

endpackage

// ==== design/spi_types_pkg.sv ====
`include "pu_spi_params.svh"

package spi_types_pkg;

  // One byte on mosi or miso
  typedef logic [`SPI_DATA_WIDTH-1:0] spi_byte_t;

  // Bit position inside a byte
  typedef logic [$clog2(`SPI_DATA_WIDTH)-1:0] spi_bit_cnt_t;

  typedef enum logic {
    IDLE,  // cs high
    SHIFT  // cs low, bits moving
  } spi_state_t;

  // Single cycle pulses from the serial side
  typedef struct packed {
    logic start;
    logic stop;
    logic byte_done;
  } spi_event_t;

endpackage

// ==== design/spi_slave_driver.sv ====
`timescale 1ns/100ps

`include "pu_spi_params.svh"

module spi_slave_driver (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sclk,
  input  logic                      mosi,
  input  logic                      cs,
  output logic                      miso,
  input  spi_types_pkg::spi_byte_t  tx_byte,
  output spi_types_pkg::spi_byte_t  rx_byte,
  output spi_types_pkg::spi_event_t event_out
);

  localparam spi_types_pkg::spi_bit_cnt_t LAST_BIT =
    spi_types_pkg::spi_bit_cnt_t'(`SPI_DATA_WIDTH - 1);

  logic [`SPI_SYNC_STAGES-1:0] sclk_sync;
  logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
  logic [`SPI_SYNC_STAGES-1:0] cs_sync;
  logic sclk_q;
  logic cs_q;
  logic sclk_s;
  logic mosi_s;
  logic cs_s;
  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;
  logic cs_fall;
  logic shifting;

  spi_types_pkg::spi_state_t   state;
  spi_types_pkg::spi_bit_cnt_t bit_cnt;
  spi_types_pkg::spi_byte_t    tx_shift;
  spi_types_pkg::spi_byte_t    rx_shift;

  // Pins enter the clk domain here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1;  // Deselected while in reset
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-2:0], sclk};
      mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], mosi};
      cs_sync   <= {cs_sync[`SPI_SYNC_STAGES-2:0], cs};
      sclk_q    <= sclk_s;
      cs_q      <= cs_s;
    end
  end

  assign sclk_s = sclk_sync[`SPI_SYNC_STAGES-1];
  assign mosi_s = mosi_sync[`SPI_SYNC_STAGES-1];
  assign cs_s   = cs_sync[`SPI_SYNC_STAGES-1];

  assign sclk_rise = sclk_s & ~sclk_q;
  assign sclk_fall = ~sclk_s & sclk_q;
  assign cs_rise   = cs_s & ~cs_q;
  assign cs_fall   = ~cs_s & cs_q;

  assign shifting = (state == spi_types_pkg::SHIFT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= spi_types_pkg::IDLE;
      bit_cnt   <= '0;
      event_out <= '0;
    end else begin
      event_out <= '0;
      case (state)
        spi_types_pkg::IDLE: begin
          bit_cnt <= '0;
          if (cs_fall) begin
            state           <= spi_types_pkg::SHIFT;
            event_out.start <= 1'b1;
          end
        end
        spi_types_pkg::SHIFT: begin
          if (cs_rise) begin
            state          <= spi_types_pkg::IDLE;
            event_out.stop <= 1'b1;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;  // Wraps to zero after the last bit
            if (bit_cnt == LAST_BIT) begin
              event_out.byte_done <= 1'b1;
            end
          end
        end
        default: state <= spi_types_pkg::IDLE;
      endcase
    end
  end

  // Mode 0: sample on rising sclk, change miso on falling sclk
  always_ff @(posedge clk) begin
    if (!shifting && cs_fall) begin
      tx_shift <= tx_byte;  // First MSB must be out before the first rise
    end else if (shifting && sclk_fall) begin
      if (bit_cnt == '0) begin
        tx_shift <= tx_byte;
      end else begin
        tx_shift <= {tx_shift[`SPI_DATA_WIDTH-2:0], 1'b0};
      end
    end
    if (shifting && sclk_rise) begin
      rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], mosi_s};
    end
  end

  // Holds the complete byte until the next rising edge
  assign rx_byte = rx_shift;

  assign miso = shifting & tx_shift[`SPI_DATA_WIDTH-1];

  // sclk half periods of four clk cycles keep byte ends apart
  a_byte_done_single: assert property (
    @(posedge clk) disable iff (rst)
    event_out.byte_done |=> !event_out.byte_done
  );

endmodule

// ==== design/spi_word_fifo.sv ====
`timescale 1ns/100ps

module spi_word_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 push,
  input  logic                 pop,
  input  pu_bus_pkg::pu_word_t wdata,
  output pu_bus_pkg::pu_word_t rdata,
  output logic                 empty,
  output logic                 full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  pu_bus_pkg::pu_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic push_ok;
  logic pop_ok;

  assign empty = (count == '0);
  assign full  = (count == FULL_CNT);

  assign push_ok = push & ~full & ~flush;
  assign pop_ok  = pop & ~empty & ~flush;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr];  // Head of queue

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= FULL_CNT
  );

endmodule

// ==== design/spi_byte_packer.sv ====
`timescale 1ns/100ps

`include "pu_spi_params.svh"

module spi_byte_packer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush,
  input  spi_types_pkg::spi_event_t spi_evt,
  input  spi_types_pkg::spi_byte_t  rx_byte,
  output spi_types_pkg::spi_byte_t  tx_byte,
  input  pu_bus_pkg::pu_word_t      tx_word,
  input  logic                      tx_empty,
  output logic                      tx_pop,
  output pu_bus_pkg::pu_word_t      rx_word,
  output logic                      rx_push
);

  localparam int BYTES = `PU_DATA_WIDTH / `SPI_DATA_WIDTH;
  localparam int CNT_W = $clog2(BYTES);
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES - 1);

  logic [CNT_W-1:0] byte_cnt;
  logic             active;
  logic             byte_in;
  logic             word_end;
  logic             fetch;

  pu_bus_pkg::pu_word_t tx_hold;
  pu_bus_pkg::pu_word_t rx_asm;
  pu_bus_pkg::pu_word_t next_word;

  assign byte_in  = spi_evt.byte_done & active;
  assign word_end = byte_in & (byte_cnt == LAST_BYTE);

  // At start the driver has just taken byte 0 of the head word.
  // At a word end the next word is fetched before its first byte goes out.
  assign fetch = ~flush & (spi_evt.start | word_end);

  assign next_word = tx_empty ? '0 : tx_word;  // Underflow sends zeros
  assign tx_pop    = fetch & ~tx_empty;

  // Outside a transfer the driver must see the head byte at cs fall
  assign tx_byte = active ? tx_hold[`PU_DATA_WIDTH-1 -: `SPI_DATA_WIDTH]
                          : next_word[`PU_DATA_WIDTH-1 -: `SPI_DATA_WIDTH];

  assign rx_word = {rx_asm[`PU_DATA_WIDTH-`SPI_DATA_WIDTH-1:0], rx_byte};
  assign rx_push = ~flush & word_end;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active   <= 1'b0;
      byte_cnt <= '0;
    end else if (flush || spi_evt.stop) begin
      active   <= 1'b0;
      byte_cnt <= '0;  // Partial word is dropped
    end else if (spi_evt.start) begin
      active   <= 1'b1;
      byte_cnt <= '0;
    end else if (byte_in) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch) begin
      tx_hold <= next_word;
    end else if (byte_in) begin
      tx_hold <= tx_hold << `SPI_DATA_WIDTH;
    end
    if (byte_in) begin
      rx_asm <= rx_word;
    end
  end

endmodule

// ==== design/pu_slave_spi.sv ====
`timescale 1ns/100ps

`include "pu_spi_params.svh"

module pu_slave_spi (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 signal_cycle,
  input  logic                 signal_wr,
  input  logic                 signal_oe,
  input  pu_bus_pkg::pu_word_t data_in,
  input  pu_bus_pkg::pu_attr_t attr_in,  // Carried for bus compatibility only
  output pu_bus_pkg::pu_word_t data_out,
  output pu_bus_pkg::pu_attr_t attr_out,
  output logic                 flag_start,
  output logic                 flag_stop,
  input  logic                 mosi,
  output logic                 miso,
  input  logic                 sclk,
  input  logic                 cs
);

  spi_types_pkg::spi_event_t spi_evt;
  spi_types_pkg::spi_byte_t  tx_byte;
  spi_types_pkg::spi_byte_t  rx_byte;

  pu_bus_pkg::pu_word_t tx_word;
  pu_bus_pkg::pu_word_t rx_word;
  pu_bus_pkg::pu_word_t rx_rdata;
  pu_bus_pkg::pu_word_t wr_data;
  pu_bus_pkg::pu_read_t read_q;
  pu_bus_pkg::pu_read_t read_next;

  logic tx_empty;
  logic tx_full;
  logic tx_pop;
  logic rx_empty;
  logic rx_full;
  logic rx_push;
  logic rx_pop;
  logic wr_q;

  spi_slave_driver spi_driver (
    .clk      (clk),
    .rst      (rst),
    .sclk     (sclk),
    .mosi     (mosi),
    .cs       (cs),
    .miso     (miso),
    .tx_byte  (tx_byte),
    .rx_byte  (rx_byte),
    .event_out(spi_evt)
  );

  spi_byte_packer byte_packer (
    .clk     (clk),
    .rst     (rst),
    .flush   (signal_cycle),
    .spi_evt (spi_evt),
    .rx_byte (rx_byte),
    .tx_byte (tx_byte),
    .tx_word (tx_word),
    .tx_empty(tx_empty),
    .tx_pop  (tx_pop),
    .rx_word (rx_word),
    .rx_push (rx_push)
  );

  spi_word_fifo #(.DEPTH(`PU_BUF_SIZE)) send_queue (
    .clk  (clk),
    .rst  (rst),
    .flush(signal_cycle),
    .push (wr_q & ~tx_full),  // Writes to a full queue are lost
    .pop  (tx_pop),
    .wdata(wr_data),
    .rdata(tx_word),
    .empty(tx_empty),
    .full (tx_full)
  );

  spi_word_fifo #(.DEPTH(`PU_BUF_SIZE)) receive_queue (
    .clk  (clk),
    .rst  (rst),
    .flush(signal_cycle),
    .push (rx_push & ~rx_full),
    .pop  (rx_pop),
    .wdata(rx_word),
    .rdata(rx_rdata),
    .empty(rx_empty),
    .full (rx_full)
  );

  // Write lands in the send queue one cycle after it is sampled
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= signal_wr & ~signal_cycle;
    end
  end

  always_ff @(posedge clk) begin
    if (signal_wr) begin
      wr_data <= data_in;
    end
  end

  assign rx_pop = signal_oe & ~signal_cycle;

  always_comb begin
    read_next = '0;
    if (rx_pop && !rx_empty) begin
      read_next.data = rx_rdata;
      read_next.attr[pu_bus_pkg::PU_ATTR_VALID] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      read_q <= '0;
    end else begin
      read_q <= read_next;
    end
  end

  assign data_out   = read_q.data;
  assign attr_out   = read_q.attr;
  assign flag_start = spi_evt.start;
  assign flag_stop  = spi_evt.stop;

  // Empty reads never leak stale queue contents
  a_invalid_read_zero: assert property (
    @(posedge clk) disable iff (rst)
    !attr_out[pu_bus_pkg::PU_ATTR_VALID] |-> (data_out == '0)
  );

endmodule

// ==== tb/tb_spi_master.svh ====
`ifndef TB_SPI_MASTER_SVH
`define TB_SPI_MASTER_SVH

// Mode 0 master model, sclk half period in clk cycles
localparam int HALF_BIT = 8;

task automatic wait_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

task automatic select_slave();
  @(negedge clk);
  cs = 1'b0;
  wait_cycles(HALF_BIT);  // Slave needs time to load its first byte
endtask

task automatic shift_byte(input spi_types_pkg::spi_byte_t tx,
                          output spi_types_pkg::spi_byte_t rx);
  for (int i = `SPI_DATA_WIDTH - 1; i >= 0; i--) begin
    mosi = tx[i];
    wait_cycles(HALF_BIT);
    sclk = 1'b1;
    rx[i] = miso;  // Master samples on the rising edge
    wait_cycles(HALF_BIT);
    sclk = 1'b0;
  end
endtask

task automatic release_slave();
  wait_cycles(HALF_BIT);
  cs = 1'b1;
  mosi = 1'b0;
  wait_cycles(2 * HALF_BIT);  // Idle gap so the stop pulse settles
endtask

// One cs frame, bytes taken from mosi_buf, captured into miso_buf
task automatic run_transfer(input int n_bytes);
  select_slave();
  for (int i = 0; i < n_bytes; i++) begin
    shift_byte(mosi_buf[i], miso_buf[i]);
  end
  release_slave();
endtask

`endif

// ==== tb/tb_pu_slave_spi.sv ====
`timescale 1ns/100ps

`include "pu_spi_params.svh"

module tb_pu_slave_spi;

  localparam int BUF_BYTES      = 32;
  localparam int BYTES_PER_WORD = `PU_DATA_WIDTH / `SPI_DATA_WIDTH;
  localparam int TEST_BYTES     = 20 + 12 + 28 + 10 + 6;  // Sum over all transfers
  localparam int TIMEOUT_CYCLES = TEST_BYTES * 8 * 16 + 2000;

  logic clk;
  logic rst;
  logic signal_cycle;
  logic signal_wr;
  logic signal_oe;
  logic mosi;
  logic sclk;
  logic cs;
  logic miso;
  logic flag_start;
  logic flag_stop;

  pu_bus_pkg::pu_word_t data_in;
  pu_bus_pkg::pu_word_t data_out;
  pu_bus_pkg::pu_attr_t attr_in;
  pu_bus_pkg::pu_attr_t attr_out;

  spi_types_pkg::spi_byte_t mosi_buf [BUF_BYTES];
  spi_types_pkg::spi_byte_t miso_buf [BUF_BYTES];
  pu_bus_pkg::pu_word_t     word_buf [`PU_BUF_SIZE + 2];

  integer seed = 32'h52b93a19;
  int cycle_count    = 0;
  int start_count    = 0;
  int stop_count     = 0;
  int transfer_count = 0;

  pu_slave_spi pu_slave_spi_inst (
    .clk         (clk),
    .rst         (rst),
    .signal_cycle(signal_cycle),
    .signal_wr   (signal_wr),
    .signal_oe   (signal_oe),
    .data_in     (data_in),
    .attr_in     (attr_in),
    .data_out    (data_out),
    .attr_out    (attr_out),
    .flag_start  (flag_start),
    .flag_stop   (flag_stop),
    .mosi        (mosi),
    .miso        (miso),
    .sclk        (sclk),
    .cs          (cs)
  );

  always #10 clk = ~clk;

  `include "tb_spi_master.svh"

  // Count one-cycle flag pulses away from the active edge
  always @(negedge clk) begin
    if (!rst) begin
      if (flag_start) start_count++;
      if (flag_stop) stop_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d clk cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Expected word from four mosi bytes with the first byte on top
  function automatic pu_bus_pkg::pu_word_t pack_word(input int first);
    pu_bus_pkg::pu_word_t w;
    w = '0;
    for (int k = 0; k < BYTES_PER_WORD; k++) begin
      w[`PU_DATA_WIDTH - 1 - k * `SPI_DATA_WIDTH -: `SPI_DATA_WIDTH] = mosi_buf[first + k];
    end
    return w;
  endfunction

  function automatic spi_types_pkg::spi_byte_t split_byte(input pu_bus_pkg::pu_word_t w,
                                                          input int idx);
    return w[`PU_DATA_WIDTH - 1 - idx * `SPI_DATA_WIDTH -: `SPI_DATA_WIDTH];
  endfunction

  task automatic report_failure(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_word(input pu_bus_pkg::pu_word_t got, input pu_bus_pkg::pu_word_t exp,
                            input string what);
    if (got !== exp) report_failure($sformatf("%s: word %h, expected %h", what, got, exp));
  endtask

  task automatic check_attr(input pu_bus_pkg::pu_attr_t got, input pu_bus_pkg::pu_attr_t exp,
                            input string what);
    if (got !== exp) report_failure($sformatf("%s: attr %b, expected %b", what, got, exp));
  endtask

  task automatic check_byte(input spi_types_pkg::spi_byte_t got,
                            input spi_types_pkg::spi_byte_t exp, input string what);
    if (got !== exp) report_failure($sformatf("%s: byte %h, expected %h", what, got, exp));
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) report_failure($sformatf("%s: level %b, expected %b", what, got, exp));
  endtask

  task automatic check_flags(input int exp_start, input int exp_stop);
    if (start_count != exp_start || stop_count != exp_stop) begin
      report_failure($sformatf("flag pulses start %0d stop %0d, expected %0d and %0d",
                               start_count, stop_count, exp_start, exp_stop));
    end
  endtask

  task automatic fill_random_words(input int n);
    for (int i = 0; i < n; i++) word_buf[i] = pu_bus_pkg::pu_word_t'($random(seed));
  endtask

  task automatic fill_random_bytes(input int n);
    for (int i = 0; i < n; i++) mosi_buf[i] = spi_types_pkg::spi_byte_t'($random(seed));
  endtask

  task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      signal_wr = 1'b1;
      data_in = word_buf[i];
    end
    @(negedge clk);
    signal_wr = 1'b0;
    data_in = '0;
  endtask

  task automatic read_expect(input pu_bus_pkg::pu_word_t exp_word, input logic valid,
                             input string what);
    pu_bus_pkg::pu_attr_t exp_attr;
    pu_bus_pkg::pu_word_t exp_data;
    exp_attr = '0;
    exp_attr[pu_bus_pkg::PU_ATTR_VALID] = valid;
    exp_data = valid ? exp_word : '0;
    @(negedge clk);
    signal_oe = 1'b1;
    @(negedge clk);
    signal_oe = 1'b0;  // Response registered at the edge in between
    check_word(data_out, exp_data, what);
    check_attr(attr_out, exp_attr, what);
  endtask

  task automatic read_packed(input int n_words);
    for (int k = 0; k < n_words; k++) begin
      read_expect(pack_word(k * BYTES_PER_WORD), 1'b1, $sformatf("received word %0d", k));
    end
  endtask

  task automatic flush_queues();
    @(negedge clk);
    signal_cycle = 1'b1;
    @(negedge clk);
    signal_cycle = 1'b0;
  endtask

  task automatic framed_transfer(input int n_bytes);
    run_transfer(n_bytes);
    transfer_count++;
    check_flags(transfer_count, transfer_count);  // One start and one stop per frame
  endtask

  // Words on miso in order and zero bytes once the send queue ran dry
  task automatic check_miso_words(input int n_words, input int n_zero, input string what);
    int n_data;
    n_data = n_words * BYTES_PER_WORD;
    for (int i = 0; i < n_data; i++) begin
      check_byte(miso_buf[i], split_byte(word_buf[i / BYTES_PER_WORD], i % BYTES_PER_WORD),
                 $sformatf("%s byte %0d", what, i));
    end
    for (int i = n_data; i < n_data + n_zero; i++) begin
      check_byte(miso_buf[i], '0, $sformatf("%s byte %0d", what, i));
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    signal_cycle = 1'b0;
    signal_wr = 1'b0;
    signal_oe = 1'b0;
    data_in = '0;
    attr_in = '0;
    mosi = 1'b0;
    sclk = 1'b0;
    cs = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    wait_cycles(2);

    check_level(flag_start, 1'b0, "flag_start after reset");
    check_level(flag_stop, 1'b0, "flag_stop after reset");
    check_level(miso, 1'b0, "miso after reset");
    check_word(data_out, '0, "data_out after reset");
    check_attr(attr_out, '0, "attr_out after reset");
    check_flags(0, 0);
    read_expect('0, 1'b0, "read after reset");

    // System to SPI with four words and four extra bytes
    fill_random_words(4);
    write_words(4);
    fill_random_bytes(20);
    framed_transfer(20);
    check_miso_words(4, 4, "send stream");

    // SPI to system
    flush_queues();
    fill_random_bytes(12);
    framed_transfer(12);
    check_miso_words(0, 12, "empty send queue");
    read_packed(3);
    read_expect('0, 1'b0, "read past received words");

    // Full duplex with both queues overflowing
    flush_queues();
    fill_random_words(`PU_BUF_SIZE + 2);
    write_words(`PU_BUF_SIZE + 2);
    fill_random_bytes(`PU_BUF_SIZE * BYTES_PER_WORD + 4);
    framed_transfer(`PU_BUF_SIZE * BYTES_PER_WORD + 4);
    check_miso_words(`PU_BUF_SIZE, 4, "overflow stream");
    read_packed(`PU_BUF_SIZE);
    read_expect('0, 1'b0, "read after overflow");

    // Flush drops the queued send word and the received one
    flush_queues();
    fill_random_words(3);
    write_words(3);
    fill_random_bytes(6);
    framed_transfer(6);
    flush_queues();
    read_expect('0, 1'b0, "read after flush");
    fill_random_bytes(4);
    framed_transfer(4);
    check_miso_words(0, 4, "stream after flush");

    // Six byte frame whose trailing two bytes never form a word
    flush_queues();
    fill_random_bytes(6);
    framed_transfer(6);
    read_packed(1);
    read_expect('0, 1'b0, "read after partial word");
    check_flags(transfer_count, transfer_count);

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== pu_slave_spi.f ====
+incdir+design
+incdir+tb
design/pu_bus_pkg.sv
design/spi_types_pkg.sv
design/spi_slave_driver.sv
design/spi_word_fifo.sv
design/spi_byte_packer.sv
design/pu_slave_spi.sv
tb/tb_pu_slave_spi.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pu_slave_spi
RTL_TOP   ?= pu_slave_spi
FILELIST  ?= pu_slave_spi.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
